// File: common/pcs_pkg.sv
package pcs_pkg;

  // Lane geometry. Every lane carries data_path_width symbols per clock.
  localparam int num_lanes = 2;
  localparam int data_path_width = 4;
  localparam int symbol_bits = 10;
  localparam int char_bits = 8;
  localparam int lane_data_width = data_path_width * symbol_bits;
  localparam int num_symbols = num_lanes * data_path_width;

  // The aligner can pick any bit offset inside one lane word.
  localparam int align_offset_width = $clog2(lane_data_width);

  // Symbols are stored with bit a of the 10-bit code in bit 0, so the
  // first bit on the line is the lowest bit of the word.
  // K28.5 with negative running disparity (abcdei fghj = 001111 1010).
  localparam logic [symbol_bits-1:0] k28_5_rdn = 10'h17c;

  // K28.5 with positive running disparity (abcdei fghj = 110000 0101).
  localparam logic [symbol_bits-1:0] k28_5_rdp = 10'h283;

  // Decoded value of the comma character.
  localparam logic [char_bits-1:0] k28_5_char = 8'hbc;

  // Aligner state. Lock is held once a comma has been seen.
  typedef enum logic {
    align_search,
    align_locked
  } align_state_e;

endpackage

// File: common/csr_pkg.sv
package csr_pkg;

  // Wishbone bus geometry. All registers are full 32-bit words.
  localparam int wb_addr_width = 4;
  localparam int wb_data_width = 32;

  // Register map, byte addresses.
  localparam logic [wb_addr_width-1:0] addr_ctrl = 4'h0;
  localparam logic [wb_addr_width-1:0] addr_status = 4'h4;
  localparam logic [wb_addr_width-1:0] addr_errcnt0 = 4'h8;
  localparam logic [wb_addr_width-1:0] addr_errcnt1 = 4'hc;

  // Bit positions inside the control register.
  localparam int ctrl_align_en_bit = 0;
  localparam int ctrl_invert_bit = 1;

  // Pattern alignment enabled, inversion off.
  localparam logic [wb_data_width-1:0] ctrl_reset_value = 32'h0000_0001;

  // Width of each per-lane decode error counter.
  localparam int errcnt_width = 16;

  typedef enum logic {
    wb_idle,
    wb_ack
  } wb_state_e;

endpackage

// File: common/pcs_symbol_if.sv
`timescale 1ns/1ps

// One clock worth of decoded symbols for all lanes.
// Lane n owns symbols n*data_path_width and up, lowest symbol first.
interface pcs_symbol_if;

  logic [pcs_pkg::num_symbols*pcs_pkg::char_bits-1:0] chars;
  logic [pcs_pkg::num_symbols-1:0] charisk;
  logic [pcs_pkg::num_symbols-1:0] notintable;
  logic [pcs_pkg::num_symbols-1:0] disperr;

  modport src (
    output chars, charisk, notintable, disperr
  );

  modport snk (
    input chars, charisk, notintable, disperr
  );

endinterface

// File: hw/pcs_rx/pattern_align.sv
`timescale 1ns/1ps

module pattern_align (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                align_en,
  input  logic [pcs_pkg::lane_data_width-1:0] in_data,
  output logic [pcs_pkg::lane_data_width-1:0] out_data,
  output logic                                lock
);

  logic [pcs_pkg::lane_data_width-1:0] prev_data;
  logic [2*pcs_pkg::lane_data_width-1:0] window;
  logic [pcs_pkg::align_offset_width-1:0] offset;
  logic [pcs_pkg::align_offset_width-1:0] match_offset;
  logic match;
  pcs_pkg::align_state_e state;

  // The older word sits in the low half, matching the order on the line.
  assign window = {in_data, prev_data};

  // Search every offset for either comma. The loop runs downwards so the
  // lowest matching offset wins when a word holds several commas.
  always_comb begin
    match = 1'b0;
    match_offset = '0;
    for (int i = pcs_pkg::lane_data_width - 1; i >= 0; i--) begin
      if (window[i +: pcs_pkg::symbol_bits] == pcs_pkg::k28_5_rdn ||
          window[i +: pcs_pkg::symbol_bits] == pcs_pkg::k28_5_rdp) begin
        match = 1'b1;
        match_offset = pcs_pkg::align_offset_width'(i);
      end
    end
  end

  // With align_en low the offset stays frozen, whatever the data holds.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pcs_pkg::align_search;
      offset <= '0;
    end else if (align_en && match) begin
      state <= pcs_pkg::align_locked;
      offset <= match_offset;
    end
  end

  always_ff @(posedge clk) begin
    prev_data <= in_data;
    out_data <= window[offset +: pcs_pkg::lane_data_width];
  end

  assign lock = (state == pcs_pkg::align_locked);

endmodule

// File: hw/pcs_rx/dec_8b10b.sv
`timescale 1ns/1ps

module dec_8b10b (
  input  logic [pcs_pkg::symbol_bits-1:0] in_char,
  input  logic                            in_disparity,
  output logic [pcs_pkg::char_bits-1:0]   out_char,
  output logic                            out_charisk,
  output logic                            out_notintable,
  output logic                            out_disperr,
  output logic                            out_disparity
);

  logic [5:0] code6;
  logic [3:0] code4;
  logic [3:0] code4_dec;
  logic [4:0] data5;
  logic [2:0] data3;
  logic valid6, valid4;
  logic d6p, d6n, n6neg, n6pos;
  logic d4p, d4n, n4neg, n4pos;
  logic req6_neg, req6_pos, req4_neg, req4_pos;
  logic det6, rd_mid, mismatch4;
  logic a7_rdn_ctx, a7_rdp_ctx, kx7_rdn, kx7_rdp;
  logic bad7;

  // Reorder into table order, abcdei and fghj, with a sent first.
  assign code6 = {in_char[0], in_char[1], in_char[2], in_char[3], in_char[4], in_char[5]};
  assign code4 = {in_char[6], in_char[7], in_char[8], in_char[9]};

  // K28 with positive disparity is the bitwise complement of the negative
  // form, so its 4b part is complemented before the table lookup.
  assign code4_dec = (code6 == 6'b110000) ? ~code4 : code4;

  always_comb begin
    valid6 = 1'b1;
    case (code6)
      6'b100111, 6'b011000: data5 = 5'd0;
      6'b011101, 6'b100010: data5 = 5'd1;
      6'b101101, 6'b010010: data5 = 5'd2;
      6'b110001:            data5 = 5'd3;
      6'b110101, 6'b001010: data5 = 5'd4;
      6'b101001:            data5 = 5'd5;
      6'b011001:            data5 = 5'd6;
      6'b111000, 6'b000111: data5 = 5'd7;
      6'b111001, 6'b000110: data5 = 5'd8;
      6'b100101:            data5 = 5'd9;
      6'b010101:            data5 = 5'd10;
      6'b110100:            data5 = 5'd11;
      6'b001101:            data5 = 5'd12;
      6'b101100:            data5 = 5'd13;
      6'b011100:            data5 = 5'd14;
      6'b010111, 6'b101000: data5 = 5'd15;
      6'b011011, 6'b100100: data5 = 5'd16;
      6'b100011:            data5 = 5'd17;
      6'b010011:            data5 = 5'd18;
      6'b110010:            data5 = 5'd19;
      6'b001011:            data5 = 5'd20;
      6'b101010:            data5 = 5'd21;
      6'b011010:            data5 = 5'd22;
      6'b111010, 6'b000101: data5 = 5'd23;
      6'b110011, 6'b001100: data5 = 5'd24;
      6'b100110:            data5 = 5'd25;
      6'b010110:            data5 = 5'd26;
      6'b110110, 6'b001001: data5 = 5'd27;
      6'b001110, 6'b001111, 6'b110000: data5 = 5'd28;
      6'b101110, 6'b010001: data5 = 5'd29;
      6'b011110, 6'b100001: data5 = 5'd30;
      6'b101011, 6'b010100: data5 = 5'd31;
      default: begin
        data5 = 5'd0;
        valid6 = 1'b0;
      end
    endcase
  end

  always_comb begin
    valid4 = 1'b1;
    case (code4_dec)
      4'b1011, 4'b0100: data3 = 3'd0;
      4'b1001:          data3 = 3'd1;
      4'b0101:          data3 = 3'd2;
      4'b1100, 4'b0011: data3 = 3'd3;
      4'b1101, 4'b0010: data3 = 3'd4;
      4'b1010:          data3 = 3'd5;
      4'b0110:          data3 = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: data3 = 3'd7;
      default: begin
        data3 = 3'd0;
        valid4 = 1'b0;
      end
    endcase
  end

  // Sub-block disparity classes. A +2 block needs RD- before it, a -2 block
  // needs RD+, and the two balanced alternates also demand a given RD.
  assign d6p = ($countones(code6) == 4);
  assign d6n = ($countones(code6) == 2);
  assign n6neg = (code6 == 6'b111000);
  assign n6pos = (code6 == 6'b000111);
  assign d4p = ($countones(code4) == 3);
  assign d4n = ($countones(code4) == 1);
  assign n4neg = (code4 == 4'b1100);
  assign n4pos = (code4 == 4'b0011);

  assign req6_neg = d6p | n6neg;
  assign req6_pos = d6n | n6pos;
  assign req4_neg = d4p | n4neg;
  assign req4_pos = d4n | n4pos;
  assign det6 = req6_neg | req6_pos;

  // Running disparity between the two sub-blocks.
  assign rd_mid = det6 ? (d6p | n6pos) : in_disparity;
  assign mismatch4 = (req4_neg & rd_mid) | (req4_pos & ~rd_mid);

  // x.7 uses the alternate form only after these 6b codes, or in K codes.
  assign a7_rdn_ctx = code6 inside {6'b100011, 6'b010011, 6'b001011};
  assign a7_rdp_ctx = code6 inside {6'b110100, 6'b101100, 6'b011100};
  assign kx7_rdn = code6 inside {6'b111010, 6'b110110, 6'b101110, 6'b011110, 6'b001111};
  assign kx7_rdp = code6 inside {6'b000101, 6'b001001, 6'b010001, 6'b100001, 6'b110000};
  assign bad7 = (code4 == 4'b1110 && a7_rdn_ctx) ||
                (code4 == 4'b0001 && a7_rdp_ctx) ||
                (code4 == 4'b0111 && !(a7_rdn_ctx || kx7_rdp)) ||
                (code4 == 4'b1000 && !(a7_rdp_ctx || kx7_rdn));

  assign out_char = {data3, data5};
  assign out_charisk = (code6 == 6'b001111) || (code6 == 6'b110000) ||
                       (code4 == 4'b1000 && kx7_rdn) ||
                       (code4 == 4'b0111 && kx7_rdp);
  assign out_notintable = !valid6 || !valid4 || (det6 && mismatch4) || bad7;

  // The first sub-block that fixes the disparity is checked against the
  // incoming running disparity.
  assign out_disperr = det6 ? ((req6_neg & in_disparity) | (req6_pos & ~in_disparity))
                            : mismatch4;

  assign out_disparity = d4p ? 1'b1 : (d4n ? 1'b0 : rd_mid);

endmodule

// File: hw/pcs_rx/soft_pcs_rx.sv
`timescale 1ns/1ps

module soft_pcs_rx (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic [pcs_pkg::num_lanes*pcs_pkg::lane_data_width-1:0] data,
  input  logic                                                  align_en,
  input  logic                                                  invert,
  output logic [pcs_pkg::num_lanes-1:0]                          lock,
  pcs_symbol_if.src                                             sym
);

  logic [pcs_pkg::num_lanes*pcs_pkg::lane_data_width-1:0] data_r;
  logic [pcs_pkg::num_lanes*pcs_pkg::lane_data_width-1:0] data_aligned;
  logic align_en_r;
  logic invert_r;

  logic [pcs_pkg::num_symbols*pcs_pkg::char_bits-1:0] chars_s;
  logic [pcs_pkg::num_symbols-1:0] charisk_s;
  logic [pcs_pkg::num_symbols-1:0] notintable_s;
  logic [pcs_pkg::num_symbols-1:0] disperr_s;

  logic [pcs_pkg::num_lanes-1:0] disparity;
  logic [pcs_pkg::num_lanes-1:0] disparity_next;

  always_ff @(posedge clk) begin
    data_r <= data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      align_en_r <= 1'b0;
      invert_r <= 1'b0;
    end else begin
      align_en_r <= align_en;
      invert_r <= invert;
    end
  end

  for (genvar lane = 0; lane < pcs_pkg::num_lanes; lane++) begin : gen_lane
    localparam int lw = pcs_pkg::lane_data_width;

    // Disparity enters at symbol 0 and ripples through the four decoders.
    logic [pcs_pkg::data_path_width:0] chain;

    pattern_align u_align (
      .clk      (clk),
      .reset    (reset),
      .align_en (align_en_r),
      .in_data  (data_r[lane*lw +: lw]),
      .out_data (data_aligned[lane*lw +: lw]),
      .lock     (lock[lane])
    );

    assign chain[0] = disparity[lane];
    assign disparity_next[lane] = chain[pcs_pkg::data_path_width];

    for (genvar i = 0; i < pcs_pkg::data_path_width; i++) begin : gen_sym
      localparam int j = lane * pcs_pkg::data_path_width + i;
      localparam int sb = pcs_pkg::symbol_bits;
      localparam int cb = pcs_pkg::char_bits;

      logic [sb-1:0] code;

      // Inversion follows the aligner, which finds either comma polarity.
      assign code = invert_r ? ~data_aligned[j*sb +: sb] : data_aligned[j*sb +: sb];

      dec_8b10b u_dec (
        .in_char        (code),
        .in_disparity   (chain[i]),
        .out_char       (chars_s[j*cb +: cb]),
        .out_charisk    (charisk_s[j]),
        .out_notintable (notintable_s[j]),
        .out_disperr    (disperr_s[j]),
        .out_disparity  (chain[i+1])
      );
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      disparity <= '0;
    end else begin
      disparity <= disparity_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sym.chars <= '0;
      sym.charisk <= '0;
      sym.notintable <= '0;
      sym.disperr <= '0;
    end else begin
      sym.chars <= chars_s;
      sym.charisk <= charisk_s;
      sym.notintable <= notintable_s;
      sym.disperr <= disperr_s;
    end
  end

endmodule

// File: hw/pcs_csr.sv
`timescale 1ns/1ps

module pcs_csr (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [csr_pkg::wb_addr_width-1:0] wb_adr,
  input  logic [csr_pkg::wb_data_width-1:0] wb_dat_w,
  output logic [csr_pkg::wb_data_width-1:0] wb_dat_r,
  output logic                              wb_ack,
  pcs_symbol_if.snk                         sym,
  input  logic [pcs_pkg::num_lanes-1:0]     lock,
  output logic                              align_en,
  output logic                              invert
);

  csr_pkg::wb_state_e state;
  logic access;
  logic wr_en;
  logic [csr_pkg::wb_data_width-1:0] rd_value;
  logic [pcs_pkg::num_lanes-1:0][csr_pkg::errcnt_width-1:0] err_count;
  logic [pcs_pkg::num_lanes-1:0] lane_err;
  logic [pcs_pkg::num_lanes-1:0] err_clr;

  // A new cycle is accepted only from idle, so each strobe gets one ack.
  assign access = wb_cyc && wb_stb && (state == csr_pkg::wb_idle);
  assign wr_en = access && wb_we;
  assign wb_ack = (state == csr_pkg::wb_ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= csr_pkg::wb_idle;
    end else begin
      case (state)
        csr_pkg::wb_idle: if (access) state <= csr_pkg::wb_ack;
        csr_pkg::wb_ack:  state <= csr_pkg::wb_idle;
        default:          state <= csr_pkg::wb_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      align_en <= csr_pkg::ctrl_reset_value[csr_pkg::ctrl_align_en_bit];
      invert <= csr_pkg::ctrl_reset_value[csr_pkg::ctrl_invert_bit];
    end else if (wr_en && wb_adr == csr_pkg::addr_ctrl) begin
      align_en <= wb_dat_w[csr_pkg::ctrl_align_en_bit];
      invert <= wb_dat_w[csr_pkg::ctrl_invert_bit];
    end
  end

  // A lane counts at most one error per clock, however many symbols are bad.
  always_comb begin
    for (int lane = 0; lane < pcs_pkg::num_lanes; lane++) begin
      lane_err[lane] = |(sym.notintable[lane*pcs_pkg::data_path_width +: pcs_pkg::data_path_width] |
                         sym.disperr[lane*pcs_pkg::data_path_width +: pcs_pkg::data_path_width]);
    end
    err_clr[0] = wr_en && (wb_adr == csr_pkg::addr_errcnt0);
    err_clr[1] = wr_en && (wb_adr == csr_pkg::addr_errcnt1);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      err_count <= '0;
    end else begin
      for (int lane = 0; lane < pcs_pkg::num_lanes; lane++) begin
        if (err_clr[lane]) begin
          err_count[lane] <= '0;
        end else if (lane_err[lane] && err_count[lane] != '1) begin
          err_count[lane] <= err_count[lane] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    rd_value = '0;
    case (wb_adr)
      csr_pkg::addr_ctrl: begin
        rd_value[csr_pkg::ctrl_align_en_bit] = align_en;
        rd_value[csr_pkg::ctrl_invert_bit] = invert;
      end
      csr_pkg::addr_status:  rd_value[pcs_pkg::num_lanes-1:0] = lock;
      csr_pkg::addr_errcnt0: rd_value[csr_pkg::errcnt_width-1:0] = err_count[0];
      csr_pkg::addr_errcnt1: rd_value[csr_pkg::errcnt_width-1:0] = err_count[1];
      default:               rd_value = '0;
    endcase
  end

  // Read data is captured with the ack and held until the next access.
  always_ff @(posedge clk) begin
    if (access) begin
      wb_dat_r <= rd_value;
    end
  end

endmodule

// File: hw/pcs_rx_top.sv
`timescale 1ns/1ps

module pcs_rx_top (
  input  logic                                                      clk,
  input  logic                                                      reset,
  input  logic [pcs_pkg::num_lanes*pcs_pkg::lane_data_width-1:0]     data,
  output logic [pcs_pkg::num_symbols*pcs_pkg::char_bits-1:0]         chars,
  output logic [pcs_pkg::num_symbols-1:0]                           charisk,
  output logic [pcs_pkg::num_symbols-1:0]                           notintable,
  output logic [pcs_pkg::num_symbols-1:0]                           disperr,
  input  logic                                                      wb_cyc,
  input  logic                                                      wb_stb,
  input  logic                                                      wb_we,
  input  logic [csr_pkg::wb_addr_width-1:0]                         wb_adr,
  input  logic [csr_pkg::wb_data_width-1:0]                         wb_dat_w,
  output logic [csr_pkg::wb_data_width-1:0]                         wb_dat_r,
  output logic                                                      wb_ack
);

  logic align_en;
  logic invert;
  logic [pcs_pkg::num_lanes-1:0] lock;

  pcs_symbol_if sym_if ();

  soft_pcs_rx u_rx (
    .clk      (clk),
    .reset    (reset),
    .data     (data),
    .align_en (align_en),
    .invert   (invert),
    .lock     (lock),
    .sym      (sym_if.src)
  );

  pcs_csr u_csr (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sym      (sym_if.snk),
    .lock     (lock),
    .align_en (align_en),
    .invert   (invert)
  );

  assign chars = sym_if.chars;
  assign charisk = sym_if.charisk;
  assign notintable = sym_if.notintable;
  assign disperr = sym_if.disperr;

endmodule

// File: dv/enc_8b10b_model.svh
`ifndef ENC_8B10B_MODEL_SVH
`define ENC_8B10B_MODEL_SVH

// Reference 8b10b encoder. Returns {new running disparity, 10-bit code} with
// bit a of the code in bit 0. Only K28.5 is supported as a control character.
function automatic logic [10:0] enc_8b10b(input logic [7:0] val, input logic is_k,
                                          input logic rd);
  logic [5:0] c6;
  logic [3:0] c4;
  logic [9:0] code;
  logic [4:0] x;
  logic [2:0] y;
  logic rd_mid;
  logic rd_out;
  if (is_k) begin
    code = rd ? pcs_pkg::k28_5_rdp : pcs_pkg::k28_5_rdn;
    return {~rd, code};
  end
  x = val[4:0];
  y = val[7:5];
  // 5b/6b codes in abcdei order, written for RD-.
  case (x)
    5'd0: c6 = 6'b100111;  5'd1: c6 = 6'b011101;  5'd2: c6 = 6'b101101;  5'd3: c6 = 6'b110001;
    5'd4: c6 = 6'b110101;  5'd5: c6 = 6'b101001;  5'd6: c6 = 6'b011001;  5'd7: c6 = 6'b111000;
    5'd8: c6 = 6'b111001;  5'd9: c6 = 6'b100101;  5'd10: c6 = 6'b010101; 5'd11: c6 = 6'b110100;
    5'd12: c6 = 6'b001101; 5'd13: c6 = 6'b101100; 5'd14: c6 = 6'b011100; 5'd15: c6 = 6'b010111;
    5'd16: c6 = 6'b011011; 5'd17: c6 = 6'b100011; 5'd18: c6 = 6'b010011; 5'd19: c6 = 6'b110010;
    5'd20: c6 = 6'b001011; 5'd21: c6 = 6'b101010; 5'd22: c6 = 6'b011010; 5'd23: c6 = 6'b111010;
    5'd24: c6 = 6'b110011; 5'd25: c6 = 6'b100110; 5'd26: c6 = 6'b010110; 5'd27: c6 = 6'b110110;
    5'd28: c6 = 6'b001110; 5'd29: c6 = 6'b101110; 5'd30: c6 = 6'b011110; default: c6 = 6'b101011;
  endcase
  // With RD+ the unbalanced codes and D.7 use the complement.
  if (rd && ($countones(c6) != 3 || c6 == 6'b111000)) c6 = ~c6;
  rd_mid = ($countones(c6) != 3) ? ~rd : rd;
  case (y)
    3'd0: c4 = 4'b1011;
    3'd1: c4 = 4'b1001;
    3'd2: c4 = 4'b0101;
    3'd3: c4 = 4'b1100;
    3'd4: c4 = 4'b1101;
    3'd5: c4 = 4'b1010;
    3'd6: c4 = 4'b0110;
    default: begin
      // The alternate x.7 avoids a run of five equal bits.
      if ((!rd_mid && x inside {5'd17, 5'd18, 5'd20}) ||
          (rd_mid && x inside {5'd11, 5'd13, 5'd14}))
        c4 = 4'b0111;
      else
        c4 = 4'b1110;
    end
  endcase
  if (rd_mid && ($countones(c4) != 2 || c4 == 4'b1100)) c4 = ~c4;
  rd_out = ($countones(c4) != 2) ? ~rd_mid : rd_mid;
  for (int k = 0; k < 6; k++) code[k] = c6[5-k];
  for (int k = 0; k < 4; k++) code[6+k] = c4[3-k];
  return {rd_out, code};
endfunction

`endif

// File: dv/tb_pcs_rx.sv
`timescale 1ns/1ps

module tb_pcs_rx;

  `include "enc_8b10b_model.svh"

  // D21.5 repeated. Valid, balanced and free of commas, so nothing locks.
  localparam logic [9:0] idle_code = 10'h155;
  localparam int lane_offset [2] = '{13, 27};

  logic clk;
  logic reset;
  logic [79:0] data;
  logic [63:0] chars;
  logic [7:0] charisk;
  logic [7:0] notintable;
  logic [7:0] disperr;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [3:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;

  // Transmit queues hold {bad disparity, byte}. Sent items move to expq.
  logic [8:0] txq [2][$];
  logic [8:0] expq [2][$];
  bit bitq [2][$];
  logic [1:0] tx_rd;
  logic stream_on;
  logic stream_started;
  logic inv_tx;
  logic check_en;
  int slip_req [2];
  int comma_cycles;
  logic [1:0] seen_comma;
  logic [1:0] seen_nit;
  logic [31:0] lcg_state;

  pcs_rx_top dut0 (
    .clk(clk), .reset(reset), .data(data), .chars(chars), .charisk(charisk),
    .notintable(notintable), .disperr(disperr), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic end_failed();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    end_failed();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    end_failed();
  endtask

  task automatic wb_access(input logic we, input logic [3:0] addr,
                           input logic [31:0] value, output logic [31:0] rdata);
    int n;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= addr;
    wb_dat_w <= value;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 20) report_timeout("Wishbone ack");
    end while (!wb_ack);
    rdata = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic wb_write(input logic [3:0] addr, input logic [31:0] value);
    logic [31:0] unused;
    wb_access(1'b1, addr, value, unused);
  endtask

  task automatic wb_read(input logic [3:0] addr, output logic [31:0] value);
    wb_access(1'b0, addr, 32'h0, value);
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected,
                           input string name);
    logic [31:0] value;
    wb_read(addr, value);
    assert (value == expected)
      else report_mismatch($sformatf("%s read %h, expected %h", name, value, expected));
  endtask

  // Waits for a clean run of commas, then clears the counters and starts checking.
  task automatic settle_checking();
    int n;
    comma_cycles = 0;
    n = 0;
    while (comma_cycles < 12) begin
      @(posedge clk);
      n++;
      if (n > 200) report_timeout("a steady comma stream");
    end
    wb_write(csr_pkg::addr_errcnt0, 32'h0);
    wb_write(csr_pkg::addr_errcnt1, 32'h0);
    expq[0].delete();
    expq[1].delete();
    check_en = 1'b1;
  endtask

  task automatic send_random(input int count);
    for (int i = 0; i < count; i++) begin
      txq[0].push_back({1'b0, next_rand()});
      txq[1].push_back({1'b0, next_rand()});
    end
  endtask

  task automatic drain_queues();
    int n;
    n = 0;
    while (txq[0].size() + txq[1].size() + expq[0].size() + expq[1].size() != 0) begin
      @(posedge clk);
      n++;
      if (n > 500) report_timeout("all sent bytes to come out");
    end
  endtask

  task automatic check_counters_zero();
    check_reg(csr_pkg::addr_errcnt0, 32'h0, "error counter 0");
    check_reg(csr_pkg::addr_errcnt1, 32'h0, "error counter 1");
  endtask

  // Serializes each lane at its own bit offset, with commas as fill.
  always @(posedge clk) begin : drive_stream
    logic [39:0] word;
    logic [10:0] enc;
    logic [8:0] item;
    logic any_data;
    any_data = 1'b0;
    if (stream_on) begin
      for (int l = 0; l < 2; l++) begin
        if (!stream_started) begin
          for (int k = 0; k < lane_offset[l]; k++) bitq[l].push_back(1'b0);
        end
        for (int k = 0; k < slip_req[l]; k++) bitq[l].push_back(1'b0);
        slip_req[l] = 0;
        while (bitq[l].size() < 40) begin
          if (txq[l].size() > 0) begin
            item = txq[l].pop_front();
            any_data = 1'b1;
            enc = enc_8b10b(item[7:0], 1'b0, item[8] ? ~tx_rd[l] : tx_rd[l]);
            expq[l].push_back(item);
          end else begin
            enc = enc_8b10b(pcs_pkg::k28_5_char, 1'b1, tx_rd[l]);
          end
          tx_rd[l] = enc[10];
          for (int b = 0; b < 10; b++) bitq[l].push_back(enc[b] ^ inv_tx);
        end
        for (int b = 0; b < 40; b++) word[b] = bitq[l].pop_front();
        data[l*40 +: 40] <= word;
      end
      stream_started = 1'b1;
      comma_cycles = any_data ? 0 : comma_cycles + 1;
    end
  end

  // Output symbols are matched in order, and commas are skipped.
  always @(posedge clk) begin : check_output
    logic [7:0] ch;
    logic [8:0] e;
    int j;
    for (int l = 0; l < 2; l++) begin
      for (int i = 0; i < 4; i++) begin
        j = l * 4 + i;
        ch = chars[j*8 +: 8];
        if (notintable[j]) seen_nit[l] = 1'b1;
        if (charisk[j] && ch == pcs_pkg::k28_5_char) begin
          if (!notintable[j] && !disperr[j]) seen_comma[l] = 1'b1;
        end else if (check_en) begin
          assert (expq[l].size() > 0)
            else report_mismatch($sformatf("lane %0d: byte %h with none expected", l, ch));
          e = expq[l].pop_front();
          if (!e[8]) begin
            assert (ch == e[7:0] && !charisk[j] && !notintable[j] && !disperr[j])
              else report_mismatch($sformatf("lane %0d: got %h k%b nit%b de%b, expected %h",
                                             l, ch, charisk[j], notintable[j], disperr[j],
                                             e[7:0]));
          end else begin
            // A symbol sent with the wrong running disparity must be flagged.
            assert (notintable[j] || disperr[j])
              else report_mismatch($sformatf("lane %0d: bad disparity symbol %h not flagged",
                                             l, ch));
          end
        end
      end
    end
  end

  initial begin : main
    logic [31:0] value;
    logic [31:0] prev;
    int n;
    lcg_state = 32'h99bc;
    reset = 1'b1;
    data = {8{idle_code}};
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    tx_rd = '0;
    stream_on = 1'b0;
    stream_started = 1'b0;
    inv_tx = 1'b0;
    check_en = 1'b0;
    slip_req = '{0, 0};
    comma_cycles = 0;
    seen_comma = '0;
    seen_nit = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    check_reg(csr_pkg::addr_ctrl, csr_pkg::ctrl_reset_value, "control after reset");
    check_reg(csr_pkg::addr_status, 32'h0, "status after reset");
    check_counters_zero();

    // Commas at offsets 13 and 27 bring both lanes to lock.
    stream_on = 1'b1;
    n = 0;
    do begin
      wb_read(csr_pkg::addr_status, value);
      n++;
      if (n > 50) report_timeout("lock on both lanes");
    end while (value[1:0] != 2'b11);
    seen_comma = '0;
    n = 0;
    while (seen_comma != 2'b11) begin
      @(posedge clk);
      n++;
      if (n > 100) report_timeout("decoded commas on both lanes");
    end

    settle_checking();
    send_random(64);
    drain_queues();
    check_counters_zero();

    // The line polarity flips, and the receiver inverts it back.
    check_en = 1'b0;
    wb_write(csr_pkg::addr_ctrl, 32'h3);
    inv_tx = 1'b1;
    settle_checking();
    send_random(64);
    drain_queues();
    check_counters_zero();

    // D0.0 sent with the wrong running disparity on lane 1 only.
    for (int i = 0; i < 8; i++) txq[1].push_back({1'b0, next_rand()});
    txq[1].push_back({1'b1, 8'h00});
    for (int i = 0; i < 8; i++) txq[1].push_back({1'b0, next_rand()});
    drain_queues();
    n = 0;
    do begin
      wb_read(csr_pkg::addr_errcnt1, value);
      n++;
      if (n > 50) report_timeout("error counter 1 to count");
    end while (value == 32'h0);
    check_reg(csr_pkg::addr_errcnt0, 32'h0, "error counter 0 after a lane 1 error");
    wb_write(csr_pkg::addr_errcnt1, 32'h0);
    check_reg(csr_pkg::addr_errcnt1, 32'h0, "error counter 1 after clear");

    // Frozen alignment while lane 0 slips by three bits.
    check_en = 1'b0;
    wb_write(csr_pkg::addr_ctrl, 32'h2);
    seen_nit = '0;
    slip_req[0] = 3;
    n = 0;
    while (!seen_nit[0]) begin
      @(posedge clk);
      n++;
      if (n > 100) report_timeout("notintable on lane 0");
    end
    check_reg(csr_pkg::addr_status, 32'h3, "status with alignment frozen");
    wb_read(csr_pkg::addr_errcnt0, prev);
    assert (prev != 32'h0) else report_mismatch("error counter 0 did not count");
    n = 0;
    do begin
      wb_read(csr_pkg::addr_errcnt0, value);
      n++;
      if (n > 50) report_timeout("error counter 0 to grow");
    end while (value <= prev);

    wb_write(csr_pkg::addr_ctrl, 32'h3);
    settle_checking();
    send_random(64);
    drain_queues();
    check_counters_zero();

    $display("Test OK");
    $finish;
  end

endmodule

// File: src.f
+incdir+dv
common/pcs_pkg.sv
common/csr_pkg.sv
common/pcs_symbol_if.sv
hw/pcs_rx/pattern_align.sv
hw/pcs_rx/dec_8b10b.sv
hw/pcs_rx/soft_pcs_rx.sv
hw/pcs_csr.sv
hw/pcs_rx_top.sv
dv/tb_pcs_rx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_pcs_rx
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
